/* verilog/acq_pkg.sv */
// shared widths, constants, sequencer state and sample record; import into each block that uses them.

package acq_pkg;

  ////////////////////////////////////////////////////////////
  // widths.
  ////////////////////////////////////////////////////////////

  // precharge pause count, in clocks.
  localparam int PRECHARGE_W = 24;

  // conversion result, the rundown count.
  localparam int RESULT_W = 20;

  // per-sample sequence number, wraps.
  localparam int SEQ_W = 8;

  ////////////////////////////////////////////////////////////
  // converter constants.
  ////////////////////////////////////////////////////////////

  // fixed integrate window of the slope converter, in clocks.
  // comp_in is ignored for this long after the adc leaves reset.
  localparam logic [15:0] INTEG_CYCLES = 16'd64;

  ////////////////////////////////////////////////////////////
  // sequencer state.
  ////////////////////////////////////////////////////////////

  // start      - entry after reset, adc held in reset.
  // load       - precharge timer loaded, led toggled.
  // wait       - adc still in reset until the timer expires.
  // measure    - adc released, waiting for measure_valid.
  // park       - halted by a falling arm/trigger edge.
  typedef enum logic [2:0] {
    START,
    PRECHARGE_LOAD,
    PRECHARGE_WAIT,
    MEASURE,
    PARK
  } acq_state_t;

  ////////////////////////////////////////////////////////////
  // sample record, one 29-bit word.
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [RESULT_W-1:0] result;
    logic [SEQ_W-1:0]    seq;
    logic                led_phase;
  } sample_rec_t;

endpackage

/* verilog/acq_sequencer.sv */
// acquisition control FSM: precharge pause, adc release, restart/park on arm_trigger edges.

module acq_sequencer (
  input  logic clk,
  input  logic arst_n,
  input  logic arm_trigger,
  input  logic timer_done,
  input  logic measure_valid,
  output logic timer_load,
  output logic adc_reset_n,
  output logic led0
);

  import acq_pkg::*;

  acq_state_t state_q;

  // two-flop synchronizer for the asynchronous arm/trigger level.
  logic [1:0] arm_sync_q;

  // previous synchronized level, for edge detection.
  logic       arm_prev_q;

  logic       arm_rise;
  logic       arm_fall;

  ////////////////////////////////////////////////////////////
  // arm/trigger edge detection.
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      arm_sync_q <= 2'b00;
      arm_prev_q <= 1'b0;
    end
    else
    begin
      // shift in, bit 1 is the synchronized level.
      arm_sync_q <= {arm_sync_q[0], arm_trigger};
      arm_prev_q <= arm_sync_q[1];
    end
  end

  // rising edge restarts, falling edge parks.
  assign arm_rise = arm_sync_q[1] & ~arm_prev_q;
  assign arm_fall = ~arm_sync_q[1] & arm_prev_q;

  ////////////////////////////////////////////////////////////
  // acquisition loop.
  ////////////////////////////////////////////////////////////

  // the timer captures its count on this pulse.
  assign timer_load = (state_q == PRECHARGE_LOAD);

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state_q     <= START;
      adc_reset_n <= 1'b0;
      led0        <= 1'b0;
    end
    else
    begin
      case (state_q)
        START:
        begin
          // one cycle with the adc held, then begin the loop.
          adc_reset_n <= 1'b0;
          state_q     <= PRECHARGE_LOAD;
        end

        PRECHARGE_LOAD:
        begin
          // one blink phase per sample, still visible at fast rates.
          led0    <= ~led0;
          state_q <= PRECHARGE_WAIT;
        end

        PRECHARGE_WAIT:
        begin
          // pause over, let the converter integrate.
          if (timer_done)
          begin
            adc_reset_n <= 1'b1;
            state_q     <= MEASURE;
          end
        end

        MEASURE:
        begin
          // conversion done, clear the adc and go round again.
          if (measure_valid)
          begin
            adc_reset_n <= 1'b0;
            state_q     <= PRECHARGE_LOAD;
          end
        end

        PARK:
        begin
          // stays here until a rising arm edge.
          adc_reset_n <= 1'b0;
        end

        default:
        begin
          adc_reset_n <= 1'b0;
          state_q     <= START;
        end
      endcase

      // edges win over the loop transition above.
      if (arm_rise)
      begin
        adc_reset_n <= 1'b0;
        state_q     <= PRECHARGE_LOAD;
      end
      else if (arm_fall)
      begin
        adc_reset_n <= 1'b0;
        state_q     <= PARK;
      end
    end
  end

endmodule

/* verilog/precharge_timer.sv */
// precharge pause timer: load a clock count, pulse done once when it runs out.

module precharge_timer (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic                         load,
  input  logic [acq_pkg::PRECHARGE_W-1:0] count_init,
  output logic                         done
);

  import acq_pkg::*;

  logic [PRECHARGE_W-1:0] count_q;
  logic                   running_q;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      count_q   <= '0;
      running_q <= 1'b0;
    end
    else if (load)
    begin
      // done lands count_init clocks after the load pulse.
      // a zero count behaves like one.
      count_q   <= (count_init == '0) ? '0 : count_init - PRECHARGE_W'(1);
      running_q <= 1'b1;
    end
    else if (running_q)
    begin
      if (count_q == '0)
      begin
        running_q <= 1'b0;
      end
      else
      begin
        count_q <= count_q - PRECHARGE_W'(1);
      end
    end
  end

  // single pulse at zero; idle timer never fires on a stale count.
  assign done = running_q & (count_q == '0);

endmodule

/* verilog/adc_slope_counter.sv */
// slope converter counter: integrate window, then rundown count until comp_in goes high.

module adc_slope_counter (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      adc_reset_n,
  input  logic                      comp_in,
  output logic                      measure_valid,
  output logic [acq_pkg::RESULT_W-1:0] result
);

  import acq_pkg::*;

  // integrate phase, counts the fixed window.
  logic        integ_q;
  logic [15:0] integ_cnt_q;

  // rundown phase, counts until the comparator trips.
  logic                rundown_q;
  logic [RESULT_W-1:0] rundown_cnt_q;

  ////////////////////////////////////////////////////////////
  // phase control.
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      integ_q       <= 1'b0;
      rundown_q     <= 1'b0;
      integ_cnt_q   <= '0;
      rundown_cnt_q <= '0;
      measure_valid <= 1'b0;
    end
    else if (!adc_reset_n)
    begin
      // held clear; the first clock after release is integrate.
      integ_q       <= 1'b1;
      rundown_q     <= 1'b0;
      integ_cnt_q   <= '0;
      rundown_cnt_q <= '0;
      measure_valid <= 1'b0;
    end
    else
    begin
      // valid is a one-clock strobe.
      measure_valid <= 1'b0;

      if (integ_q)
      begin
        // comp_in is ignored for the whole window.
        integ_cnt_q <= integ_cnt_q + 16'd1;
        if (integ_cnt_q == INTEG_CYCLES - 16'd1)
        begin
          integ_q   <= 1'b0;
          rundown_q <= 1'b1;
        end
      end
      else if (rundown_q)
      begin
        if (comp_in)
        begin
          // comparator tripped, report clocks counted so far.
          rundown_q     <= 1'b0;
          measure_valid <= 1'b1;
        end
        else if (rundown_cnt_q != '1)
        begin
          // saturates rather than wrapping on a stuck comparator.
          rundown_cnt_q <= rundown_cnt_q + RESULT_W'(1);
        end
      end
      // neither phase set: done, idle until the next reset.
    end
  end

  ////////////////////////////////////////////////////////////
  // result register.
  ////////////////////////////////////////////////////////////

  // payload only, updated alongside measure_valid.
  always_ff @(posedge clk)
  begin
    if (adc_reset_n && rundown_q && comp_in)
    begin
      result <= rundown_cnt_q;
    end
  end

endmodule

/* verilog/sample_latch.sv */
// sample latch: turns each measure_valid into a sample record and a one-cycle strobe.

module sample_latch (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic                         measure_valid,
  input  logic [acq_pkg::RESULT_W-1:0] result,
  input  logic                         led0,
  output acq_pkg::sample_rec_t         sample,
  output logic                         sample_strobe
);

  import acq_pkg::*;

  // sequence number for the next sample, wraps at SEQ_W bits.
  logic [SEQ_W-1:0] seq_q;

  ////////////////////////////////////////////////////////////
  // control: strobe and sequence counter.
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      seq_q         <= '0;
      sample_strobe <= 1'b0;
    end
    else
    begin
      // one cycle after measure_valid, together with the record.
      sample_strobe <= measure_valid;
      if (measure_valid)
      begin
        seq_q <= seq_q + SEQ_W'(1);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // payload: the sample record.
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (measure_valid)
    begin
      sample.result    <= result;
      sample.seq       <= seq_q;
      // led phase of the precharge that led to this sample.
      sample.led_phase <= led0;
    end
  end

endmodule

/* verilog/acq_top.sv */
// acquisition top level: sequencer, precharge timer, slope converter and sample latch.

module acq_top (
  input  logic                            clk,
  input  logic                            arst_n,
  input  logic                            arm_trigger,
  input  logic [acq_pkg::PRECHARGE_W-1:0] p_clk_count_precharge,
  input  logic                            comp_in,
  output acq_pkg::sample_rec_t            sample,
  output logic                            sample_strobe,
  output logic                            led0,
  output logic [1:0]                      monitor
);

  import acq_pkg::*;

  // sequencer to timer.
  logic timer_load;
  logic timer_done;

  // sequencer to converter, the adc reset level.
  logic adc_reset_n;

  // converter to sequencer and latch.
  logic                measure_valid;
  logic [RESULT_W-1:0] result;

  ////////////////////////////////////////////////////////////
  // control.
  ////////////////////////////////////////////////////////////

  acq_sequencer u_sequencer (
    .clk           (clk),
    .arst_n        (arst_n),
    .arm_trigger   (arm_trigger),
    .timer_done    (timer_done),
    .measure_valid (measure_valid),
    .timer_load    (timer_load),
    .adc_reset_n   (adc_reset_n),
    .led0          (led0)
  );

  ////////////////////////////////////////////////////////////
  // datapath.
  ////////////////////////////////////////////////////////////

  // times the precharge pause with the adc held.
  precharge_timer u_timer (
    .clk        (clk),
    .arst_n     (arst_n),
    .load       (timer_load),
    .count_init (p_clk_count_precharge),
    .done       (timer_done)
  );

  adc_slope_counter u_adc (
    .clk           (clk),
    .arst_n        (arst_n),
    .adc_reset_n   (adc_reset_n),
    .comp_in       (comp_in),
    .measure_valid (measure_valid),
    .result        (result)
  );

  sample_latch u_latch (
    .clk           (clk),
    .arst_n        (arst_n),
    .measure_valid (measure_valid),
    .result        (result),
    .led0          (led0),
    .sample        (sample),
    .sample_strobe (sample_strobe)
  );

  // scope pins: bit 0 adc reset, bit 1 measure valid.
  assign monitor[0] = adc_reset_n;
  assign monitor[1] = measure_valid;

endmodule

/* bench/tb_clock_gen.sv */
// testbench clock and reset source; 8-unit clock period, reset held low for 8 cycles.

module tb_clock_gen (
  output logic clk,
  output logic arst_n
);

  // half of the 8-unit period.
  localparam int HALF_PERIOD  = 4;
  localparam int RESET_CYCLES = 8;

  initial
  begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // release away from the rising edge.
  initial
  begin
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
  end

endmodule

/* bench/acq_tb.sv */
// testbench for acq_top with comparator model, trigger stimulus and assertion checks, run as top.

module acq_tb;

  import acq_pkg::*;

  localparam logic [31:0] SEED = 32'h949bf9e3;

  logic                   clk;
  logic                   arst_n;
  logic                   arm_trigger;
  logic [PRECHARGE_W-1:0] p_clk_count_precharge;
  logic                   comp_in;
  sample_rec_t            sample;
  logic                   sample_strobe;
  logic                   led0;
  logic [1:0]             monitor;

  int value_errs;
  int timeout_errs;
  int strobes;
  event abort_ev;

  // monitor and model state.
  int               cyc;
  int               gap_start;
  bit               gap_armed;
  int               exp_pre;
  int               cur_delay;
  int               comp_cnt;
  bit               comp_run;
  bit               rst_prev;
  bit               arm_seen;
  logic [RESULT_W-1:0] exp_result;
  logic [SEQ_W-1:0] exp_seq;

  // led phase of the next conversion and of the one in flight.
  bit               exp_led;
  bit               cur_led;

  tb_clock_gen u_clk (
    .clk    (clk),
    .arst_n (arst_n)
  );

  acq_top DUT (
    .clk                   (clk),
    .arst_n                (arst_n),
    .arm_trigger           (arm_trigger),
    .p_clk_count_precharge (p_clk_count_precharge),
    .comp_in               (comp_in),
    .sample                (sample),
    .sample_strobe         (sample_strobe),
    .led0                  (led0),
    .monitor               (monitor)
  );

  ////////////////////////////////////////////////////////////
  // strobe follows measure_valid by one cycle.
  ////////////////////////////////////////////////////////////

  assert property (@(posedge clk) disable iff (!arst_n) monitor[1] |=> sample_strobe)
  else
  begin
    value_errs++;
    $display("ERROR sample_strobe exp 0x1 got 0x%h", sample_strobe);
  end

  assert property (@(posedge clk) disable iff (!arst_n) sample_strobe |-> $past(monitor[1]))
  else
  begin
    value_errs++;
    $display("ERROR sample_strobe exp 0x0 got 0x%h", sample_strobe);
  end

  ////////////////////////////////////////////////////////////
  // run control.
  ////////////////////////////////////////////////////////////

  task automatic finish_run;
    $display("errors: value=%0d timeout=%0d", value_errs, timeout_errs);
    if (value_errs + timeout_errs == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  endtask

  // a timeout ends the run from its own process.
  always @(abort_ev)
  begin
    finish_run();
  end

  task automatic report_timeout(input string what);
    timeout_errs++;
    $display("timeout while waiting for %s", what);
    -> abort_ev;
  endtask

  task automatic wait_strobes(input int n, input int limit);
    int target;
    int t;
    target = strobes + n;
    t = 0;
    while (strobes < target && t < limit)
    begin
      @(negedge clk);
      t++;
    end
    if (strobes < target)
      report_timeout("sample strobes");
  endtask

  task automatic wait_release(input int limit);
    int t;
    t = 0;
    while (monitor[0] !== 1'b1 && t < limit)
    begin
      @(negedge clk);
      t++;
    end
    if (monitor[0] !== 1'b1)
      report_timeout("adc release");
  endtask

  task automatic wait_reset_done(input int limit);
    int t;
    t = 0;
    while (arst_n !== 1'b1 && t < limit)
    begin
      @(negedge clk);
      t++;
    end
    if (arst_n !== 1'b1)
      report_timeout("end of reset");
  endtask

  ////////////////////////////////////////////////////////////
  // monitor, reference model and comparator model.
  ////////////////////////////////////////////////////////////

  always @(negedge clk)
  begin
    if (arst_n)
    begin
      cyc++;
      // a trigger change breaks the normal loop timing.
      if (arm_trigger != arm_seen)
      begin
        gap_armed = 1'b0;
        // a rising edge forces one more precharge load and led toggle.
        if (arm_trigger)
          exp_led = ~exp_led;
      end
      arm_seen = arm_trigger;

      if (sample_strobe)
      begin
        assert (sample.result == exp_result)
        else
        begin
          value_errs++;
          $display("ERROR sample.result exp 0x%h got 0x%h", exp_result, sample.result);
        end
        assert (sample.seq == exp_seq)
        else
        begin
          value_errs++;
          $display("ERROR sample.seq exp 0x%h got 0x%h", exp_seq, sample.seq);
        end
        assert (sample.led_phase == cur_led)
        else
        begin
          value_errs++;
          $display("ERROR sample.led_phase exp 0x%h got 0x%h", cur_led, sample.led_phase);
        end
        // led0 holds this phase until the next precharge load.
        assert (led0 == cur_led)
        else
        begin
          value_errs++;
          $display("ERROR led0 exp 0x%h got 0x%h", cur_led, led0);
        end
        exp_seq   = exp_seq + SEQ_W'(1);
        strobes++;
      end

      if (monitor[1])
      begin
        exp_result = RESULT_W'(cur_delay);
        // this sample keeps the phase, the following load flips it.
        cur_led    = exp_led;
        exp_led    = ~exp_led;
        gap_start  = cyc;
        gap_armed  = 1'b1;
      end

      if (monitor[0] && !rst_prev)
      begin
        // on release check the hold time, then pick the next conversion.
        if (gap_armed)
        begin
          assert (cyc - gap_start == exp_pre + 2)
          else
          begin
            value_errs++;
            $display("ERROR adc_reset_n low cycles exp 0x%h got 0x%h",
                     exp_pre + 2, cyc - gap_start);
          end
        end
        gap_armed = 1'b0;
        cur_delay = int'($urandom % 51);
        exp_pre   = 4 + int'($urandom % 37);
        p_clk_count_precharge = PRECHARGE_W'(exp_pre);
        comp_cnt  = 0;
        comp_run  = 1'b1;
      end
      else if (monitor[0] && comp_run)
      begin
        // comparator trips after the window plus the chosen delay.
        comp_cnt++;
        if (comp_cnt == int'(INTEG_CYCLES) + cur_delay)
          comp_in = 1'b1;
      end

      if (!monitor[0])
      begin
        comp_in  = 1'b0;
        comp_run = 1'b0;
      end
      rst_prev = monitor[0];
    end
  end

  ////////////////////////////////////////////////////////////
  // stimulus.
  ////////////////////////////////////////////////////////////

  initial
  begin
    void'($urandom(SEED));
    value_errs   = 0;
    timeout_errs = 0;
    strobes      = 0;
    cyc          = 0;
    gap_armed    = 1'b0;
    rst_prev     = 1'b0;
    arm_seen     = 1'b0;
    comp_run     = 1'b0;
    exp_seq      = '0;
    exp_result   = '0;
    cur_delay    = 0;
    // led0 leaves reset low and the first load sets it.
    exp_led      = 1'b1;
    cur_led      = 1'b0;
    arm_trigger  = 1'b0;
    comp_in      = 1'b0;
    exp_pre      = 4 + int'($urandom % 37);
    p_clk_count_precharge = PRECHARGE_W'(exp_pre);

    wait_reset_done(100);

    // free-running loop long enough to wrap seq.
    wait_strobes(260, 60000);

    // rising edge during measure restarts with the adc held.
    wait_release(500);
    @(negedge clk);
    arm_trigger = 1'b1;
    repeat (4) @(negedge clk);
    assert (monitor[0] == 1'b0)
    else
    begin
      value_errs++;
      $display("ERROR adc_reset_n exp 0x0 got 0x%h", monitor[0]);
    end
    wait_strobes(3, 1000);

    // falling edge parks the sequencer.
    @(negedge clk);
    arm_trigger = 1'b0;
    repeat (4) @(negedge clk);
    repeat (200)
    begin
      @(negedge clk);
      assert (monitor[0] == 1'b0 && sample_strobe == 1'b0)
      else
      begin
        value_errs++;
        $display("ERROR park adc_reset_n 0x%h sample_strobe 0x%h", monitor[0], sample_strobe);
      end
    end

    // rising edge in park restarts the loop.
    arm_trigger = 1'b1;
    wait_strobes(3, 1000);

    if (timeout_errs == 0)
      finish_run();
  end

endmodule

/* list.f */
verilog/acq_pkg.sv
verilog/acq_sequencer.sv
verilog/precharge_timer.sv
verilog/adc_slope_counter.sv
verilog/sample_latch.sv
verilog/acq_top.sv
bench/tb_clock_gen.sv
bench/acq_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the acquisition sequencer testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f list.f --top-module acq_tb --Mdir obj_dir -o acq_sim \
  && ./obj_dir/acq_sim | tee /dev/stderr | grep -q "STATUS: PASS" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
